//--- hw/smc_pkg.sv
// Static memory controller shared definitions
`default_nettype none

package smc_pkg;

  // --------------------------------------------------------------------------
  // Bus sizes and memory window
  // --------------------------------------------------------------------------
  localparam int unsigned smc_addr_w = 32;          // AHB and EMI address
  localparam int unsigned smc_data_w = 32;          // All data buses
  localparam int unsigned smc_be_w   = smc_data_w / 8; // Byte lanes

  // External SRAM window, 64 KiB from zero
  localparam logic [smc_addr_w-1:0] smc_mem_bytes = 32'h0001_0000;

  // --------------------------------------------------------------------------
  // Register map, APB offsets
  // --------------------------------------------------------------------------
  localparam logic [4:0] smc_reg_timing = 5'h00;    // Timing word, r/w
  localparam logic [4:0] smc_reg_status = 5'h04;    // Busy in bit 0, r/o

  // Writable bits of the timing word
  localparam logic [31:0] smc_timing_mask = 32'h0000_01ff;
  // Enable set, one wait state each way
  localparam logic [31:0] smc_timing_rst  = 32'h0000_0111;

  // Timing word as decoded by the AHB slave and the sequencer
  typedef struct packed {
    logic [22:0] reserved;                          // Reads as zero
    logic        enable;                            // Bit 8
    logic [3:0]  wr_wait;                           // Bits 7:4
    logic [3:0]  rd_wait;                           // Bits 3:0
  } smc_timing_t;

  // Same word, raw on the APB side
  typedef union packed {
    logic [31:0] raw;
    smc_timing_t fields;
  } smc_timing_u;

  // AHB HRESP encoding
  typedef enum logic [1:0] {
    resp_okay  = 2'b00,
    resp_error = 2'b01
  } smc_resp_e;

  // One accepted transfer, AHB slave to sequencer
  typedef struct packed {
    logic [smc_addr_w-1:0] addr;
    logic [smc_be_w-1:0]   be;                      // Active high lanes
    logic                  write;
  } smc_req_t;

  // EMI pin bundle, strobes active low
  typedef struct packed {
    logic [smc_addr_w-1:0] addr;
    logic [smc_data_w-1:0] data;                    // Write data out
    logic [smc_be_w-1:0]   n_be;
    logic                  n_cs;
    logic [smc_be_w-1:0]   n_we;                    // Per-lane write strobes
    logic                  n_wr;
    logic                  n_rd;
    logic                  n_ext_oe;                // Write data drive enable
  } smc_emi_t;

  // Pins at rest: all strobes inactive
  localparam smc_emi_t smc_emi_rst = '{addr: '0, data: '0, n_be: '1, n_cs: 1'b1,
                                       n_we: '1, n_wr: 1'b1, n_rd: 1'b1,
                                       n_ext_oe: 1'b1};

endpackage

`default_nettype wire

//--- hw/smc_cfg_regs.sv
// Timing and status registers
`timescale 1ns/1ps
`default_nettype none

module smc_cfg_regs import smc_pkg::*; (
  input  logic                  hclk,
  input  logic                  rst_n,
  // APB strobes, same clock as AHB
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [4:0]            paddr,
  input  logic [smc_data_w-1:0] pwdata,
  // Status from the sequencer
  input  logic                  busy,
  output logic [smc_data_w-1:0] prdata,
  output smc_timing_u           timing
);

  smc_timing_u           timing_q;                  // Programmed word
  logic                  wr_en;                     // APB access phase write
  logic [smc_data_w-1:0] status_word;

  // --------------------------------------------------------------------------
  // Write path
  // --------------------------------------------------------------------------
  assign wr_en = psel & penable & pwrite;

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      timing_q.raw <= smc_timing_rst;               // Enabled, 1/1 waits
    end else if (wr_en && paddr == smc_reg_timing) begin
      timing_q.raw <= pwdata & smc_timing_mask;     // Reserved bits stay zero
    end
  end

  assign timing = timing_q;

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------
  assign status_word = {{(smc_data_w-1){1'b0}}, busy};

  // Combinational from paddr while selected
  always_comb begin
    prdata = '0;
    if (psel) begin
      case (paddr)
        smc_reg_timing: prdata = timing_q.raw;
        smc_reg_status: prdata = status_word;
        default:        prdata = '0;            // Unmapped offsets
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/smc_ahb_slave.sv
// AHB-lite slave front end
`timescale 1ns/1ps
`default_nettype none

module smc_ahb_slave import smc_pkg::*; (
  input  logic                  hclk,
  input  logic                  rst_n,
  // AHB address phase
  input  logic [smc_addr_w-1:0] haddr,
  input  logic [1:0]            htrans,
  input  logic                  hsel,
  input  logic                  hwrite,
  input  logic [2:0]            hsize,
  input  logic                  hready,             // Muxed bus ready
  input  smc_timing_u           timing,
  // Sequencer handshake
  input  logic                  done,
  input  logic [smc_data_w-1:0] rdata,
  output smc_req_t              req,
  output logic                  start,
  // AHB response
  output logic                  smc_hready,
  output smc_resp_e             smc_hresp,
  output logic [smc_data_w-1:0] smc_hrdata,
  output logic                  smc_valid
);

  typedef enum logic [1:0] {
    st_idle,                                        // Ready, okay
    st_wait,                                        // EMI cycle running
    st_err1,                                        // Error, ready low
    st_err2                                         // Error, ready high
  } slv_state_e;

  slv_state_e state;
  logic       accept;                               // Transfer taken this edge
  logic       in_window;
  logic       good;                                 // Goes to the EMI

  // --------------------------------------------------------------------------
  // Address phase decode
  // --------------------------------------------------------------------------
  // NONSEQ or SEQ, only while our own ready is high
  assign accept    = hsel & htrans[1] & hready & smc_hready;
  assign in_window = (haddr < smc_mem_bytes);
  assign good      = in_window & timing.fields.enable;
  assign start     = accept & good;                 // Sequencer loads setup on this edge

  // Little endian lanes from size and low address bits
  always_comb begin
    req.addr  = haddr;
    req.write = hwrite;
    case (hsize)
      3'b000:  req.be = 4'b0001 << haddr[1:0];      // Byte
      3'b001:  req.be = haddr[1] ? 4'b1100 : 4'b0011; // Halfword
      default: req.be = 4'b1111;                    // Word and wider
    endcase
  end

  // --------------------------------------------------------------------------
  // Wait and response FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      smc_hready <= 1'b1;
      smc_hresp  <= resp_okay;
      smc_valid  <= 1'b0;
    end else begin
      smc_valid <= start;                           // One cycle per good transfer
      case (state)
        st_idle, st_err2: begin
          smc_hready <= 1'b1;
          smc_hresp  <= resp_okay;
          state      <= st_idle;
          if (accept) begin
            smc_hready <= 1'b0;
            if (good) begin
              state <= st_wait;
            end else begin
              smc_hresp <= resp_error;              // No EMI cycle
              state     <= st_err1;
            end
          end
        end
        st_wait: if (done) begin
          smc_hready <= 1'b1;                       // Data phase ends next cycle
          state      <= st_idle;
        end
        st_err1: begin
          smc_hready <= 1'b1;                       // Second error cycle
          state      <= st_err2;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Read data held for the last data phase cycle
  always_ff @(posedge hclk) begin
    if (state == st_wait && done) smc_hrdata <= rdata;
  end

endmodule

`default_nettype wire

//--- hw/smc_emi_seq.sv
// External memory cycle sequencer
`timescale 1ns/1ps
`default_nettype none

module smc_emi_seq import smc_pkg::*; (
  input  logic                  hclk,
  input  logic                  rst_n,
  input  smc_req_t              req,
  input  logic                  start,
  input  logic [smc_data_w-1:0] hwdata,             // AHB data phase
  input  logic [smc_data_w-1:0] data_smc,           // EMI read data
  input  smc_timing_u           timing,
  output smc_emi_t              emi,
  output logic [smc_data_w-1:0] rdata,
  output logic                  done,
  output logic                  busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,                                       // CS, address, lanes valid
    st_strobe,                                      // wait+1 cycles
    st_hold                                         // Strobes high, CS low
  } seq_state_e;

  seq_state_e          state;
  logic [3:0]          cnt;                         // Strobe cycles left minus one
  logic                write_q;
  logic [smc_be_w-1:0] be_q;
  logic                last_strobe;

  assign last_strobe = (state == st_strobe) && (cnt == '0);
  assign busy        = (state != st_idle);

  // --------------------------------------------------------------------------
  // Cycle FSM, every pin registered
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      cnt     <= '0;
      write_q <= 1'b0;
      be_q    <= '0;
      done    <= 1'b0;
      emi     <= smc_emi_rst;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: if (start) begin
          emi.addr <= req.addr;
          emi.n_be <= ~req.be;
          emi.n_cs <= 1'b0;
          write_q  <= req.write;
          be_q     <= req.be;
          state    <= st_setup;
        end
        st_setup: begin
          // Data phase of the AHB write is now on hwdata
          cnt <= write_q ? timing.fields.wr_wait : timing.fields.rd_wait;
          if (write_q) begin
            emi.data     <= hwdata;
            emi.n_we     <= ~be_q;                  // Enabled lanes only
            emi.n_wr     <= 1'b0;
            emi.n_ext_oe <= 1'b0;
          end else begin
            emi.n_rd <= 1'b0;
          end
          state <= st_strobe;
        end
        st_strobe: begin
          cnt <= cnt - 4'd1;
          if (last_strobe) begin
            emi.n_we <= '1;                         // Rising edge writes the SRAM
            emi.n_wr <= 1'b1;
            emi.n_rd <= 1'b1;
            done     <= 1'b1;                       // High during hold
            state    <= st_hold;
          end
        end
        st_hold: begin
          emi.n_cs     <= 1'b1;
          emi.n_be     <= '1;
          emi.n_ext_oe <= 1'b1;                     // Data held through hold
          state        <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Sample at the end of the last strobe cycle
  always_ff @(posedge hclk) begin
    if (last_strobe && !write_q) rdata <= data_smc;
  end

endmodule

`default_nettype wire

//--- hw/smc_veneer.sv
// Static memory controller top level
`timescale 1ns/1ps
`default_nettype none

module smc_veneer import smc_pkg::*; (
  input  logic                  hclk,
  input  logic                  rst_n,
  // AHB slave port
  input  logic [smc_addr_w-1:0] haddr,
  input  logic [1:0]            htrans,
  input  logic                  hsel,
  input  logic                  hwrite,
  input  logic [2:0]            hsize,
  input  logic [smc_data_w-1:0] hwdata,
  input  logic                  hready,
  output logic [smc_data_w-1:0] smc_hrdata,
  output logic                  smc_hready,
  output smc_resp_e             smc_hresp,
  output logic                  smc_valid,
  // APB strobes for the config block
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [4:0]            paddr,
  input  logic [smc_data_w-1:0] pwdata,
  output logic [smc_data_w-1:0] prdata,
  // External memory interface
  output logic [smc_addr_w-1:0] smc_addr,
  output logic [smc_data_w-1:0] smc_data,
  input  logic [smc_data_w-1:0] data_smc,
  output logic [smc_be_w-1:0]   smc_n_be,
  output logic                  smc_n_cs,
  output logic                  smc_n_wr,
  output logic [smc_be_w-1:0]   smc_n_we,
  output logic                  smc_n_rd,
  output logic                  smc_n_ext_oe,
  output logic                  smc_busy
);

  smc_timing_u           timing;
  smc_req_t              req;
  smc_emi_t              emi;
  logic                  start;
  logic                  done;
  logic                  busy;
  logic [smc_data_w-1:0] rdata;

  smc_cfg_regs i_cfg_regs (
    .hclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .busy, .prdata, .timing
  );

  smc_ahb_slave i_ahb_slave (
    .hclk, .rst_n, .haddr, .htrans, .hsel, .hwrite, .hsize, .hready,
    .timing, .done, .rdata, .req, .start,
    .smc_hready, .smc_hresp, .smc_hrdata, .smc_valid
  );

  smc_emi_seq i_emi_seq (
    .hclk, .rst_n, .req, .start, .hwdata, .data_smc, .timing,
    .emi, .rdata, .done, .busy
  );

  // EMI bundle out to the pins
  assign smc_addr     = emi.addr;
  assign smc_data     = emi.data;
  assign smc_n_be     = emi.n_be;
  assign smc_n_cs     = emi.n_cs;
  assign smc_n_we     = emi.n_we;
  assign smc_n_wr     = emi.n_wr;
  assign smc_n_rd     = emi.n_rd;
  assign smc_n_ext_oe = emi.n_ext_oe;
  assign smc_busy     = busy;

endmodule

`default_nettype wire

//--- verification/smc_tb.sv
// Static memory controller testbench
`timescale 1ns/1ps
`default_nettype none

module smc_tb import smc_pkg::*; ();

  logic        hclk;
  logic        rst_n;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hsel;
  logic        hwrite;
  logic [2:0]  hsize;
  logic [31:0] hwdata;
  logic        hready;
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  smc_resp_e   smc_hresp;
  logic        smc_valid;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic [31:0] smc_addr;
  logic [31:0] smc_data;
  logic [31:0] data_smc;
  logic [3:0]  smc_n_be;
  logic        smc_n_cs;
  logic        smc_n_wr;
  logic [3:0]  smc_n_we;
  logic        smc_n_rd;
  logic        smc_n_ext_oe;
  logic        smc_busy;

  logic [7:0]  sram   [0:smc_mem_bytes-1];          // Behavioral SRAM
  logic [7:0]  shadow [0:smc_mem_bytes-1];          // Predicted contents
  logic [15:0] rd_base;
  logic [3:0]  rd_lanes;                            // Lanes driven on a read
  logic [3:0]  we_armed = 4'h0;                     // Lanes in a valid write strobe
  int          cs_cnt = 0;                          // EMI cycles seen
  int          valid_cnt = 0;                       // smc_valid pulses seen
  int          busy_cnt = 0;                        // Cycles with smc_busy high
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  bit          test_bad;
  bit          abort_run = 1'b0;
  integer      seed;
  smc_timing_u timing_model;                        // Expected timing word

  smc_veneer UUT (.*);

  always #5 hclk = ~hclk;

  // --------------------------------------------------------------------------
  // SRAM model
  // --------------------------------------------------------------------------
  assign rd_base  = {smc_addr[15:2], 2'b00};
  assign rd_lanes = {4{smc_n_rd === 1'b0 && smc_n_cs === 1'b0}} & ~smc_n_be;
  assign data_smc = {rd_lanes[3] ? sram[rd_base + 16'd3] : 8'h00,
                     rd_lanes[2] ? sram[rd_base + 16'd2] : 8'h00,
                     rd_lanes[1] ? sram[rd_base + 16'd1] : 8'h00,
                     rd_lanes[0] ? sram[rd_base] : 8'h00};

  // Chip selected, write cycle and data driven, lane enabled
  always @(negedge hclk) begin
    we_armed = ~smc_n_we & ~smc_n_be &
               {4{smc_n_cs === 1'b0 && smc_n_wr === 1'b0 && smc_n_ext_oe === 1'b0}};
  end

  // Armed lanes written on the rising n_we edge
  always @(smc_n_we) begin
    for (int i = 0; i < 4; i++) begin
      if (we_armed[i] === 1'b1 && smc_n_we[i] === 1'b1)
        sram[{smc_addr[15:2], 2'b00} + i] = smc_data[8*i +: 8];
    end
  end

  always @(negedge smc_n_cs) cs_cnt++;              // One per EMI cycle

  always @(negedge hclk) begin
    if (smc_valid === 1'b1) valid_cnt++;
    if (smc_busy === 1'b1) busy_cnt++;
  end

  // --------------------------------------------------------------------------
  // Checks and bus tasks
  // --------------------------------------------------------------------------
  task automatic check_word(input string test, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error %s %s: expected %h, actual %h", test, what, exp, act);
      test_bad = 1'b1;
    end
  endtask

  task automatic check_resp(input string test, input smc_resp_e exp, input smc_resp_e act);
    if (exp !== act) begin
      $display("error %s hresp: expected %s, actual %s", test, exp.name(), act.name());
      test_bad = 1'b1;
    end
  endtask

  // Lanes in the same size-aligned group as the address
  function automatic logic [3:0] lane_mask(input int size, input logic [1:0] off);
    int         nbytes;
    logic [3:0] m;
    nbytes = (size >= 2) ? 4 : (1 << size);
    m = '0;
    for (int i = 0; i < 4; i++)
      m[i] = (i / nbytes) == (off / nbytes);
    return m;
  endfunction

  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    logic [15:0] b;
    b = {addr[15:2], 2'b00};
    return {shadow[b + 16'd3], shadow[b + 16'd2], shadow[b + 16'd1], shadow[b]};
  endfunction

  task automatic apb_access(input logic wr, input logic [4:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge hclk);
    psel    <= 1'b1;                                // Setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge hclk);
    penable <= 1'b1;
    @(negedge hclk);
    rdata = prdata;                                 // Combinational read data
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // Address phase, data phase, then wait for smc_hready
  task automatic ahb_transfer(input string test, input logic wr, input logic [31:0] addr,
                              input int size, input logic [31:0] wdata, output int n_low,
                              output smc_resp_e resp, output logic [31:0] rdata);
    bit ready_seen;
    @(posedge hclk);
    hsel   <= 1'b1;
    htrans <= 2'b10;                                // NONSEQ
    haddr  <= addr;
    hwrite <= wr;
    hsize  <= size[2:0];
    @(posedge hclk);                                // Accepted here
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwdata <= wdata;
    n_low = 0;
    ready_seen = 1'b0;
    for (int c = 0; c < 200 && !ready_seen; c++) begin
      @(negedge hclk);
      if (smc_hready) ready_seen = 1'b1;
      else n_low++;
    end
    if (!ready_seen) begin
      $display("timeout: smc_hready stayed low for 200 cycles in %s", test);
      abort_run = 1'b1;
    end
    resp  = smc_hresp;
    rdata = smc_hrdata;
  endtask

  // --------------------------------------------------------------------------
  // Case file runner
  // --------------------------------------------------------------------------
  initial begin
    int            fd;
    int            n;
    int            size;
    int            chk;
    int            n_low;
    int            exp_low;
    int            cs_before;
    int            valid_before;
    int            busy_before;
    string         name;
    string         kind;
    string         resp_s;
    logic [8*128-1:0] line;
    logic [31:0]   addr;
    logic [31:0]   data;
    logic [31:0]   got;
    logic [3:0]    lanes;
    smc_resp_e     exp_resp;
    smc_resp_e     got_resp;
    hclk = 1'b0;
    rst_n = 1'b0;
    {haddr, htrans, hsel, hwrite, hsize, hwdata} = '0;
    hready = 1'b1;                                  // Bus always ready
    {psel, penable, pwrite, paddr, pwdata} = '0;
    seed = 19389;
    for (int a = 0; a < smc_mem_bytes; a++) begin
      n = $random(seed);
      sram[a] = n[7:0];
      shadow[a] = n[7:0];
    end
    timing_model.raw = 32'h0000_0111;               // Enabled with one wait each way
    repeat (8) @(posedge hclk);
    rst_n <= 1'b1;
    fd = $fopen("verification/smc_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      abort_run = 1'b1;
    end
    while (!abort_run && $fgets(line, fd) > 0) begin
      n = $sscanf(line, "%s %s %h %d %h %s %d", name, kind, addr, size, data, resp_s, chk);
      if (n == 7 && name[0] != "#") begin
        test_bad = 1'b0;
        exp_resp = (resp_s == "error") ? resp_error : resp_okay;
        if (kind == "apb_wr") begin
          apb_access(1'b1, addr[4:0], data, got);
          if (addr[4:0] == 5'h00) timing_model.raw = data & 32'h0000_01ff; // Enable and waits
        end else if (kind == "apb_rd") begin
          apb_access(1'b0, addr[4:0], 32'h0, got);
          check_word(name, "prdata", data, got);
        end else begin
          cs_before = cs_cnt;
          valid_before = valid_cnt;
          busy_before = busy_cnt;
          ahb_transfer(name, kind == "ahb_wr", addr, size, data, n_low, got_resp, got);
          check_resp(name, exp_resp, got_resp);
          // All strobes back high once the transfer ends
          check_word(name, "emi pins at rest", 32'h0000_0fff,
                     {20'h0, smc_n_be, smc_n_we, smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe});
          if (exp_resp == resp_okay) begin
            exp_low = 3 + ((kind == "ahb_wr") ?
                      timing_model.fields.wr_wait : timing_model.fields.rd_wait);
            check_word(name, "emi cycles", 1, cs_cnt - cs_before);
            check_word(name, "valid pulses", 1, valid_cnt - valid_before);
            check_word(name, "ready low cycles", exp_low, n_low);
            check_word(name, "busy cycles", exp_low, busy_cnt - busy_before);
            lanes = lane_mask(size, addr[1:0]);
            if (kind == "ahb_wr") begin
              for (int i = 0; i < 4; i++)
                if (lanes[i]) shadow[{addr[15:2], 2'b00} + i] = data[8*i +: 8];
            end else begin
              check_word(name, "read data", chk ? data : shadow_word(addr), got);
            end
          end else begin
            check_word(name, "emi cycles", 0, cs_cnt - cs_before); // No strobe at all
            check_word(name, "valid pulses", 0, valid_cnt - valid_before);
            check_word(name, "busy cycles", 0, busy_cnt - busy_before);
            check_word(name, "ready low cycles", 1, n_low);
          end
        end
        if (test_bad || abort_run) begin
          fail_cnt++;
          $display("%s: failed", name);
        end else begin
          pass_cnt++;
          $display("%s: ok", name);
        end
      end
    end
    if (fd != 0) $fclose(fd);
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !abort_run) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/smc_cases.txt
# name kind addr(hex) hsize data(hex) resp chk
# chk 1 compares read data with the data column, chk 0 predicts it from the shadow memory
st_idle  apb_rd 00000004 2 00000000 okay  1
tim_rst  apb_rd 00000000 2 00000111 okay  1
tim_wr   apb_wr 00000000 2 fffff123 okay  0
tim_rd   apb_rd 00000000 2 00000123 okay  1
wd_wr    ahb_wr 00000100 2 cafef00d okay  0
wd_rd    ahb_rd 00000100 2 cafef00d okay  1
b1_wr    ahb_wr 00000101 0 0000aa00 okay  0
b3_wr    ahb_wr 00000103 0 5a000000 okay  0
bm_rd    ahb_rd 00000100 2 5afeaa0d okay  1
hu_wr    ahb_wr 00000202 1 beef1234 okay  0
hu_rd    ahb_rd 00000200 2 00000000 okay  0
hl_wr    ahb_wr 00000300 1 0000c0de okay  0
hl_rd    ahb_rd 00000300 2 00000000 okay  0
pre_rd   ahb_rd 00001230 2 00000000 okay  0
top_rd   ahb_rd 0000fffc 2 00000000 okay  0
oow_wr   ahb_wr 00010000 2 12345678 error 0
oow_rd   ahb_rd 80000000 2 00000000 error 0
dis      apb_wr 00000000 2 00000045 okay  0
dis_rd   ahb_rd 00000100 2 00000000 error 0
dis_wr   ahb_wr 00000100 2 deadbeef error 0
en_w15   apb_wr 00000000 2 000001f0 okay  0
w15_wr   ahb_wr 00000400 2 01234567 okay  0
r0_rd    ahb_rd 00000400 2 01234567 okay  1
keep_rd  ahb_rd 00000100 2 5afeaa0d okay  1
st_end   apb_rd 00000004 2 00000000 okay  1

//--- smc_lite.f
hw/smc_pkg.sv
hw/smc_cfg_regs.sv
hw/smc_ahb_slave.sv
hw/smc_emi_seq.sv
hw/smc_veneer.sv
verification/smc_tb.sv

//--- Bender.yml
package:
  name: smc_lite

sources:
  - hw/smc_pkg.sv
  - hw/smc_cfg_regs.sv
  - hw/smc_ahb_slave.sv
  - hw/smc_emi_seq.sv
  - hw/smc_veneer.sv
  - target: simulation
    files:
      - verification/smc_tb.sv
